//--- rx_wide_pkg.sv
////////////////////////////////////////////////////////////
// rx wide adapter shared definitions
// word widths, lane counts, tag bit positions and the
// end-of-packet byte map encoder
////////////////////////////////////////////////////////////

package rx_wide_pkg;

	// data word and lane counts
	localparam int WORD_LEN  = 64;
	localparam int WORDS_IN  = 5;
	localparam int WORDS_OUT = 8;
	// sop, eop valid, eop index (3), fcs valid, fcs error
	localparam int TAG_LEN   = 7;
	localparam int ANN_LEN   = WORD_LEN + TAG_LEN;
	// data plus the two fcs bits, as handed to the output stage
	localparam int DAT_LEN   = WORD_LEN + 2;
	// word count 0..WORDS_OUT
	localparam int CNT_LEN   = $clog2(WORDS_OUT + 1);

	// tag layout, data sits in the low WORD_LEN bits
	localparam int SOP_BIT   = ANN_LEN - 1;
	localparam int EOPV_BIT  = ANN_LEN - 2;
	localparam int EIDX_LSB  = WORD_LEN + 2;
	localparam int FCSV_BIT  = WORD_LEN + 1;
	localparam int FCSE_BIT  = WORD_LEN;

	// byte map to index of its set bit, zero for an empty map
	function automatic logic [2:0] encode_eop_byte(input logic [7:0] bm);
		logic [2:0] idx;
		idx = '0;
		for (int b = 0; b < 8; b++)
		begin
			if (bm[b])
				idx = idx | 3'(b);
		end
		return idx;
	endfunction

endpackage

//--- rx_lane_annotate.sv
////////////////////////////////////////////////////////////
// rx lane annotate
// registers the five-lane receive words, follows packet
// state across cycles and tags each word with sop, eop
// position and fcs result, plus a keep mask that drops the
// junk words lying between packets
////////////////////////////////////////////////////////////

module rx_lane_annotate
	import rx_wide_pkg::*;
(
	input  logic                          arst,
	input  logic                          clk_rxmac,
	input  logic [WORDS_IN*WORD_LEN-1:0]  rx5l_d,
	input  logic [WORDS_IN-1:0]           rx5l_sop,
	input  logic [WORDS_IN*8-1:0]         rx5l_eop_bm,
	input  logic                          rx5l_valid,
	input  logic                          rx5l_fcs_valid,
	input  logic                          rx5l_fcs_error,
	output logic [WORDS_IN*ANN_LEN-1:0]   ann_words,
	output logic [WORDS_IN-1:0]           ann_mask
);

	////////////////////////////////////////////////////////////
	// stage 1 input registers
	////////////////////////////////////////////////////////////

	logic                         valid_q;
	logic [WORDS_IN-1:0]          sop_q;
	logic [WORDS_IN*8-1:0]        eop_bm_q;
	logic                         fcs_valid_q;
	logic                         fcs_error_q;
	logic [WORDS_IN*WORD_LEN-1:0] d_q;

	// flags are forced low on idle cycles so no stray sop/eop leaks in
	always_ff @(posedge clk_rxmac or posedge arst)
	begin
		if (arst)
		begin
			valid_q     <= 1'b0;
			sop_q       <= '0;
			eop_bm_q    <= '0;
			fcs_valid_q <= 1'b0;
			fcs_error_q <= 1'b0;
		end
		else
		begin
			valid_q     <= rx5l_valid;
			sop_q       <= rx5l_valid ? rx5l_sop : '0;
			eop_bm_q    <= rx5l_valid ? rx5l_eop_bm : '0;
			fcs_valid_q <= rx5l_valid & rx5l_fcs_valid;
			fcs_error_q <= rx5l_valid & rx5l_fcs_error;
		end
	end

	always_ff @(posedge clk_rxmac)
	begin
		d_q <= rx5l_d;
	end

	////////////////////////////////////////////////////////////
	// per-lane eop decode and annotation
	////////////////////////////////////////////////////////////

	logic [WORDS_IN-1:0] eop_v;
	logic [ANN_LEN-1:0]  ann_d [WORDS_IN];

	for (genvar i = 0; i < WORDS_IN; i++)
	begin : g_lane
		assign eop_v[i] = |eop_bm_q[i*8 +: 8];
		// fcs result only sticks to the word that closes the packet
		assign ann_d[i] = {sop_q[i], eop_v[i], encode_eop_byte(eop_bm_q[i*8 +: 8]),
			fcs_valid_q & eop_v[i], fcs_error_q & eop_v[i],
			d_q[i*WORD_LEN +: WORD_LEN]};
	end

	// in_packet carries packet state from one cycle to the next
	logic in_packet;

	always_ff @(posedge clk_rxmac or posedge arst)
	begin
		if (arst)
			in_packet <= 1'b0;
		else if ((|sop_q) && !(|eop_v))
			in_packet <= 1'b1;
		else if (!(|sop_q) && (|eop_v))
			in_packet <= 1'b0;
	end

	// scan lanes in wire order, lane 4 first
	// a word is kept when a packet is open at it or starts on it
	logic [WORDS_IN-1:0] keep;

	always_comb
	begin
		logic run;
		run = in_packet;
		for (int i = WORDS_IN - 1; i >= 0; i--)
		begin
			keep[i] = run | sop_q[i];
			run = keep[i] & ~eop_v[i];
		end
		if (!valid_q)
			keep = '0;
	end

	////////////////////////////////////////////////////////////
	// stage 2 output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_rxmac or posedge arst)
	begin
		if (arst)
			ann_mask <= '0;
		else
			ann_mask <= keep;
	end

	always_ff @(posedge clk_rxmac)
	begin
		for (int i = 0; i < WORDS_IN; i++)
			ann_words[i*ANN_LEN +: ANN_LEN] <= ann_d[i];
	end

	// input protocol: one packet start and one end per cycle at most
	a_one_sop: assert property (@(posedge clk_rxmac) disable iff (arst)
		$onehot0(sop_q));
	a_one_eop: assert property (@(posedge clk_rxmac) disable iff (arst)
		$onehot0(eop_v));

	// each lane byte map names a single last byte
	for (genvar i = 0; i < WORDS_IN; i++)
	begin : g_bm_chk
		a_bm_onehot: assert property (@(posedge clk_rxmac) disable iff (arst)
			$onehot0(eop_bm_q[i*8 +: 8]));
	end

endmodule

//--- rx_word_compact.sv
////////////////////////////////////////////////////////////
// rx word compact
// packs the kept annotated words into a dense run at the
// top of an eight-word bus and counts them, one cycle
////////////////////////////////////////////////////////////

module rx_word_compact
	import rx_wide_pkg::*;
(
	input  logic                          arst,
	input  logic                          clk_rxmac,
	input  logic [WORDS_IN*ANN_LEN-1:0]   ann_words,
	input  logic [WORDS_IN-1:0]           ann_mask,
	output logic [WORDS_OUT*ANN_LEN-1:0]  cmp_words,
	output logic [CNT_LEN-1:0]            cmp_count
);

	logic [ANN_LEN-1:0] slot [WORDS_OUT];
	logic [CNT_LEN-1:0] count;

	// walk lanes from the top, each kept word takes the next
	// free slot going down from word 7
	// e.g. mask 10001 lands in slots 7 and 6
	always_comb
	begin
		int pos;
		pos = WORDS_OUT - 1;
		count = '0;
		for (int s = 0; s < WORDS_OUT; s++)
			slot[s] = '0;
		for (int i = WORDS_IN - 1; i >= 0; i--)
		begin
			if (ann_mask[i])
			begin
				slot[pos] = ann_words[i*ANN_LEN +: ANN_LEN];
				pos = pos - 1;
				count = count + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_rxmac or posedge arst)
	begin
		if (arst)
			cmp_count <= '0;
		else
			cmp_count <= count;
	end

	// unused slots are zero so no stale tags reach the regroup buffer
	always_ff @(posedge clk_rxmac)
	begin
		for (int s = 0; s < WORDS_OUT; s++)
			cmp_words[s*ANN_LEN +: ANN_LEN] <= slot[s];
	end

	// only five lanes feed the compactor
	a_count_max: assert property (@(posedge clk_rxmac) disable iff (arst)
		cmp_count <= CNT_LEN'(WORDS_IN));

endmodule

//--- rx_sop_regroup.sv
////////////////////////////////////////////////////////////
// rx sop regroup
// buffers compacted words and emits eight-word beats so
// that every packet starts at the top word of a beat and
// every beat stops at a packet end
// words that do not fit the buffer are dropped and flagged
////////////////////////////////////////////////////////////

module rx_sop_regroup
	import rx_wide_pkg::*;
#(
	parameter int BUF_WORDS = 16
)
(
	input  logic                          arst,
	input  logic                          clk_rxmac,
	input  logic [WORDS_OUT*ANN_LEN-1:0]  cmp_words,
	input  logic [CNT_LEN-1:0]            cmp_count,
	output logic [WORDS_OUT*DAT_LEN-1:0]  grp_words,
	output logic [CNT_LEN-1:0]            grp_count,
	output logic                          grp_sop,
	output logic                          grp_eop,
	output logic [2:0]                    grp_eop_idx,
	output logic                          grp_overflow
);

	localparam int PTR_LEN = $clog2(BUF_WORDS + 1);

	// buf_q[0] is the oldest pending word
	logic [ANN_LEN-1:0] buf_q [BUF_WORDS];
	logic [ANN_LEN-1:0] buf_d [BUF_WORDS];
	logic [PTR_LEN-1:0] buf_cnt;
	logic [PTR_LEN-1:0] buf_cnt_d;
	logic [CNT_LEN-1:0] emit_cnt;
	logic [ANN_LEN-1:0] last_word;
	logic               drop;
	logic               ovf_pend;

	////////////////////////////////////////////////////////////
	// beat size selection
	////////////////////////////////////////////////////////////

	// look at up to eight pending words
	// a sop past the first word closes the beat in front of it
	// an eop closes the beat after itself
	// with neither, wait for a full beat
	always_comb
	begin
		logic found;
		int   lim;
		found = 1'b0;
		emit_cnt = '0;
		lim = (int'(buf_cnt) < WORDS_OUT) ? int'(buf_cnt) : WORDS_OUT;
		for (int j = 0; j < WORDS_OUT; j++)
		begin
			if (!found && j < lim)
			begin
				if (j > 0 && buf_q[j][SOP_BIT])
				begin
					emit_cnt = CNT_LEN'(j);
					found = 1'b1;
				end
				else if (buf_q[j][EOPV_BIT])
				begin
					emit_cnt = CNT_LEN'(j + 1);
					found = 1'b1;
				end
			end
		end
		if (!found && lim == WORDS_OUT)
			emit_cnt = CNT_LEN'(WORDS_OUT);
	end

	// last word of the beat carries eop flag and index
	assign last_word = (emit_cnt == '0) ? '0 : buf_q[emit_cnt - 1'b1];

	////////////////////////////////////////////////////////////
	// buffer update
	////////////////////////////////////////////////////////////

	// shift out the emitted words, then append the new run
	// new words come in from cmp word 7 downward
	always_comb
	begin
		int keep;
		int fill;
		keep = int'(buf_cnt) - int'(emit_cnt);
		fill = keep + int'(cmp_count);
		drop = fill > BUF_WORDS;
		for (int j = 0; j < BUF_WORDS; j++)
		begin
			buf_d[j] = buf_q[j];
			if (j < keep)
				buf_d[j] = buf_q[j + int'(emit_cnt)];
			else if (!drop && j < fill)
				buf_d[j] = cmp_words[(WORDS_OUT - 1 - (j - keep))*ANN_LEN +: ANN_LEN];
		end
		buf_cnt_d = drop ? PTR_LEN'(keep) : PTR_LEN'(fill);
	end

	always_ff @(posedge clk_rxmac)
	begin
		for (int j = 0; j < BUF_WORDS; j++)
			buf_q[j] <= buf_d[j];
	end

	////////////////////////////////////////////////////////////
	// control and beat flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_rxmac or posedge arst)
	begin
		if (arst)
		begin
			buf_cnt      <= '0;
			ovf_pend     <= 1'b0;
			grp_count    <= '0;
			grp_sop      <= 1'b0;
			grp_eop      <= 1'b0;
			grp_eop_idx  <= '0;
			grp_overflow <= 1'b0;
		end
		else
		begin
			buf_cnt      <= buf_cnt_d;
			// an overflow waits for the next beat to be reported
			ovf_pend     <= (emit_cnt == '0) & (ovf_pend | drop);
			grp_overflow <= (emit_cnt != '0) & (ovf_pend | drop);
			grp_count    <= emit_cnt;
			grp_sop      <= (emit_cnt != '0) & buf_q[0][SOP_BIT];
			grp_eop      <= last_word[EOPV_BIT];
			grp_eop_idx  <= last_word[EIDX_LSB +: 3];
		end
	end

	// beat data, first word at the top, unused words zero
	always_ff @(posedge clk_rxmac)
	begin
		for (int j = 0; j < WORDS_OUT; j++)
		begin
			grp_words[(WORDS_OUT - 1 - j)*DAT_LEN +: DAT_LEN] <=
				(j < int'(emit_cnt)) ? buf_q[j][DAT_LEN-1:0] : '0;
		end
	end

	a_eop_has_words: assert property (@(posedge clk_rxmac) disable iff (arst)
		grp_eop |-> (grp_count != '0));

endmodule

//--- rx_wide_528.sv
////////////////////////////////////////////////////////////
// rx wide 5-to-8 word adapter, top level
// turns the five-lane receive stream into 512-bit beats
// aligned to packet start, with empty count and fcs flags
////////////////////////////////////////////////////////////

module rx_wide_528
	import rx_wide_pkg::*;
#(
	parameter int BUF_WORDS = 16
)
(
	input  logic                          arst,
	input  logic                          clk_rxmac,
	input  logic [WORDS_IN*WORD_LEN-1:0]  rx5l_d,
	input  logic [WORDS_IN-1:0]           rx5l_sop,
	input  logic [WORDS_IN*8-1:0]         rx5l_eop_bm,
	input  logic                          rx5l_valid,
	input  logic                          rx5l_fcs_valid,
	input  logic                          rx5l_fcs_error,
	output logic [WORDS_OUT*WORD_LEN-1:0] rx8l_d,
	output logic                          rx8l_sop,
	output logic                          rx8l_eop,
	output logic [5:0]                    rx8l_empty,
	output logic                          rx8l_error,
	output logic                          rx8l_fcs_valid,
	output logic                          rx8l_fcs_error,
	output logic                          rx8l_wrreq
);

	logic [WORDS_IN*ANN_LEN-1:0]  ann_words;
	logic [WORDS_IN-1:0]          ann_mask;
	logic [WORDS_OUT*ANN_LEN-1:0] cmp_words;
	logic [CNT_LEN-1:0]           cmp_count;
	logic [WORDS_OUT*DAT_LEN-1:0] grp_words;
	logic [CNT_LEN-1:0]           grp_count;
	logic                         grp_sop;
	logic                         grp_eop;
	logic [2:0]                   grp_eop_idx;
	logic                         grp_overflow;

	rx_lane_annotate i_annotate (
		.arst           (arst),
		.clk_rxmac      (clk_rxmac),
		.rx5l_d         (rx5l_d),
		.rx5l_sop       (rx5l_sop),
		.rx5l_eop_bm    (rx5l_eop_bm),
		.rx5l_valid     (rx5l_valid),
		.rx5l_fcs_valid (rx5l_fcs_valid),
		.rx5l_fcs_error (rx5l_fcs_error),
		.ann_words      (ann_words),
		.ann_mask       (ann_mask)
	);

	rx_word_compact i_compact (
		.arst      (arst),
		.clk_rxmac (clk_rxmac),
		.ann_words (ann_words),
		.ann_mask  (ann_mask),
		.cmp_words (cmp_words),
		.cmp_count (cmp_count)
	);

	rx_sop_regroup #(
		.BUF_WORDS (BUF_WORDS)
	) i_regroup (
		.arst         (arst),
		.clk_rxmac    (clk_rxmac),
		.cmp_words    (cmp_words),
		.cmp_count    (cmp_count),
		.grp_words    (grp_words),
		.grp_count    (grp_count),
		.grp_sop      (grp_sop),
		.grp_eop      (grp_eop),
		.grp_eop_idx  (grp_eop_idx),
		.grp_overflow (grp_overflow)
	);

	////////////////////////////////////////////////////////////
	// output beat
	////////////////////////////////////////////////////////////

	// fcs bits only live on the eop word, unused words are zero
	logic       fcs_v_any;
	logic       fcs_e_any;
	logic [6:0] empty_full;

	always_comb
	begin
		fcs_v_any = 1'b0;
		fcs_e_any = 1'b0;
		for (int j = 0; j < WORDS_OUT; j++)
		begin
			fcs_v_any = fcs_v_any | grp_words[j*DAT_LEN + FCSV_BIT];
			fcs_e_any = fcs_e_any | grp_words[j*DAT_LEN + FCSE_BIT];
		end
	end

	// missing words count eight bytes each, plus unused tail of the last word
	assign empty_full = 7'(WORDS_OUT * 8) - {grp_count, 3'b000} + {4'b0000, grp_eop_idx};

	always_ff @(posedge clk_rxmac or posedge arst)
	begin
		if (arst)
		begin
			rx8l_wrreq     <= 1'b0;
			rx8l_sop       <= 1'b0;
			rx8l_eop       <= 1'b0;
			rx8l_empty     <= '0;
			rx8l_error     <= 1'b0;
			rx8l_fcs_valid <= 1'b0;
			rx8l_fcs_error <= 1'b0;
		end
		else
		begin
			rx8l_wrreq     <= |grp_count;
			rx8l_sop       <= grp_sop;
			rx8l_eop       <= grp_eop;
			rx8l_empty     <= empty_full[5:0];
			rx8l_error     <= grp_overflow;
			rx8l_fcs_valid <= fcs_v_any;
			rx8l_fcs_error <= fcs_e_any;
		end
	end

	// strip the fcs bits off each word
	always_ff @(posedge clk_rxmac)
	begin
		for (int j = 0; j < WORDS_OUT; j++)
			rx8l_d[j*WORD_LEN +: WORD_LEN] <= grp_words[j*DAT_LEN +: WORD_LEN];
	end

endmodule

//--- tb_rx_wide_528.sv
////////////////////////////////////////////////////////////
// testbench for the rx wide 5-to-8 word adapter
// reads packet patterns, packs them onto the five lanes
// with junk words and idle cycles, and checks each output
// beat against a byte-level model of the packet
////////////////////////////////////////////////////////////

module tb_rx_wide_528;

	localparam int MAX_PKTS  = 64;
	localparam int MAX_BYTES = 2048;

	logic         arst;
	logic         clk_rxmac;
	logic [319:0] rx5l_d;
	logic [4:0]   rx5l_sop;
	logic [39:0]  rx5l_eop_bm;
	logic         rx5l_valid;
	logic         rx5l_fcs_valid;
	logic         rx5l_fcs_error;
	logic [511:0] rx8l_d;
	logic         rx8l_sop;
	logic         rx8l_eop;
	logic [5:0]   rx8l_empty;
	logic         rx8l_error;
	logic         rx8l_fcs_valid;
	logic         rx8l_fcs_error;
	logic         rx8l_wrreq;

	rx_wide_528 #(
		.BUF_WORDS (16)
	) i_dut (
		.arst           (arst),
		.clk_rxmac      (clk_rxmac),
		.rx5l_d         (rx5l_d),
		.rx5l_sop       (rx5l_sop),
		.rx5l_eop_bm    (rx5l_eop_bm),
		.rx5l_valid     (rx5l_valid),
		.rx5l_fcs_valid (rx5l_fcs_valid),
		.rx5l_fcs_error (rx5l_fcs_error),
		.rx8l_d         (rx8l_d),
		.rx8l_sop       (rx8l_sop),
		.rx8l_eop       (rx8l_eop),
		.rx8l_empty     (rx8l_empty),
		.rx8l_error     (rx8l_error),
		.rx8l_fcs_valid (rx8l_fcs_valid),
		.rx8l_fcs_error (rx8l_fcs_error),
		.rx8l_wrreq     (rx8l_wrreq)
	);

	// pattern table, one entry per packet line
	int pat_len  [MAX_PKTS];
	int pat_junk [MAX_PKTS];
	int pat_idle [MAX_PKTS];
	int pat_fv   [MAX_PKTS];
	int pat_fe   [MAX_PKTS];
	int n_pkts;

	integer seed;
	int     cycle_cnt;
	int     cycle_limit;

	// expected beats in output order
	// flags are sop, eop, fcs valid, fcs error, error
	logic [511:0] exp_d     [$];
	logic [4:0]   exp_flags [$];
	logic [5:0]   exp_empty [$];
	string        exp_name  [$];

	// input cycle being filled, lane 4 goes first
	logic [63:0] cyc_d [5];
	logic [4:0]  cyc_sop;
	logic [39:0] cyc_bm;
	logic        cyc_fv;
	logic        cyc_fe;
	int          lane;
	logic [7:0]  pkt_bytes [MAX_BYTES];

	always #50 clk_rxmac = ~clk_rxmac;

	////////////////////////////////////////////////////////////
	// failure reporting and compare
	////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [511:0] expected,
		input logic [511:0] actual);
		if (actual !== expected)
			fail_run($sformatf("error %s: expected %0h, actual %0h", name, expected, actual));
	endtask

	////////////////////////////////////////////////////////////
	// pattern file
	////////////////////////////////////////////////////////////

	task automatic read_patterns();
		int               fd;
		int               n;
		int               len;
		int               junk;
		int               idle;
		int               fv;
		int               fe;
		int               in_cycles;
		logic [8*128-1:0] line;
		fd = $fopen("rx_wide_patterns.txt", "r");
		if (fd == 0)
			fail_run("could not open the pattern file rx_wide_patterns.txt");
		n_pkts = 0;
		in_cycles = 0;
		while (!$feof(fd) && n_pkts < MAX_PKTS)
		begin
			line = '0;
			n = $fgets(line, fd);
			// comment lines scan to fewer than five fields
			if (n > 0 && $sscanf(line, "%d %d %d %d %d", len, junk, idle, fv, fe) == 5)
			begin
				if (len < 1 || len > MAX_BYTES)
					fail_run($sformatf("packet line %0d has a length out of range", n_pkts));
				pat_len[n_pkts]  = len;
				pat_junk[n_pkts] = junk;
				pat_idle[n_pkts] = idle;
				pat_fv[n_pkts]   = fv;
				pat_fe[n_pkts]   = fe;
				// idle, lane cycles rounded up, two cycles of padding at most
				in_cycles = in_cycles + idle + (junk + (len + 7) / 8 + 4) / 5 + 2;
				n_pkts++;
			end
		end
		$fclose(fd);
		if (n_pkts == 0)
			fail_run("the pattern file held no packet lines");
		cycle_limit = (in_cycles + 1) * 2 + 200;
	endtask

	////////////////////////////////////////////////////////////
	// expected beats
	////////////////////////////////////////////////////////////

	// one beat per 64 bytes or part, first byte at the top
	task automatic queue_beats(input int p);
		int           len;
		int           nbeats;
		int           k;
		logic [511:0] beat;
		logic         last;
		len = pat_len[p];
		nbeats = (len + 63) / 64;
		for (int b = 0; b < nbeats; b++)
		begin
			beat = '0;
			last = (b == nbeats - 1);
			for (int o = 0; o < 64; o++)
			begin
				k = 64 * b + o;
				if (k < len)
					beat[511 - 8*o -: 8] = pkt_bytes[k];
			end
			exp_d.push_back(beat);
			exp_flags.push_back({b == 0, last, last & (pat_fv[p] != 0),
				last & (pat_fe[p] != 0), 1'b0});
			exp_empty.push_back(last ? 6'(64 * nbeats - len) : 6'd0);
			exp_name.push_back($sformatf("packet %0d beat %0d", p, b));
		end
	endtask

	////////////////////////////////////////////////////////////
	// lane driving
	////////////////////////////////////////////////////////////

	task automatic send_cycle();
		@(negedge clk_rxmac);
		rx5l_valid = 1'b1;
		for (int i = 0; i < 5; i++)
			rx5l_d[i*64 +: 64] = cyc_d[i];
		rx5l_sop       = cyc_sop;
		rx5l_eop_bm    = cyc_bm;
		rx5l_fcs_valid = cyc_fv;
		rx5l_fcs_error = cyc_fe;
		cyc_sop = '0;
		cyc_bm  = '0;
		cyc_fv  = 1'b0;
		cyc_fe  = 1'b0;
		lane    = 4;
	endtask

	// the DUT drops sop, eop and fcs bits while valid is low
	task automatic send_idle();
		@(negedge clk_rxmac);
		rx5l_valid = 1'b0;
		for (int i = 0; i < 5; i++)
			rx5l_d[i*64 +: 64] = {$random(seed), $random(seed)};
		rx5l_sop       = 5'($random(seed));
		rx5l_eop_bm    = 40'({$random(seed), $random(seed)});
		rx5l_fcs_valid = 1'($random(seed));
		rx5l_fcs_error = 1'($random(seed));
	endtask

	task automatic put_word(input logic [63:0] data, input logic sop, input logic [7:0] bm,
		input logic fv, input logic fe);
		cyc_d[lane] = data;
		cyc_sop[lane] = sop;
		cyc_bm[lane*8 +: 8] = bm;
		// fcs belongs to the word that ends the packet
		if (bm != 8'h00)
		begin
			cyc_fv = fv;
			cyc_fe = fe;
		end
		lane = lane - 1;
		if (lane < 0)
			send_cycle();
	endtask

	// fill the rest of the cycle with junk
	task automatic pad_cycle();
		while (lane != 4)
			put_word({$random(seed), $random(seed)}, 1'b0, 8'h00, 1'b0, 1'b0);
	endtask

	task automatic drive_packet(input int p);
		int          len;
		int          nwords;
		int          last_n;
		int          k;
		logic [63:0] word;
		logic [7:0]  bm;
		len = pat_len[p];
		nwords = (len + 7) / 8;
		last_n = len - 8 * (nwords - 1);
		for (k = 0; k < len; k++)
			pkt_bytes[k] = 8'($random(seed));
		queue_beats(p);
		// idle cycles start on a cycle boundary
		if (pat_idle[p] > 0)
		begin
			pad_cycle();
			repeat (pat_idle[p]) send_idle();
		end
		repeat (pat_junk[p]) put_word({$random(seed), $random(seed)}, 1'b0, 8'h00, 1'b0, 1'b0);
		// at most one sop and one eop per input cycle
		if ((|cyc_sop) || ((|cyc_bm) && nwords <= lane + 1))
			pad_cycle();
		for (int w = 0; w < nwords; w++)
		begin
			word = '0;
			for (int j = 0; j < 8; j++)
			begin
				k = 8 * w + j;
				if (k < len)
					word[63 - 8*j -: 8] = pkt_bytes[k];
			end
			// bit e set means byte e is the last valid one
			bm = (w == nwords - 1) ? 8'(1 << (8 - last_n)) : 8'h00;
			put_word(word, w == 0, bm, pat_fv[p] != 0, pat_fe[p] != 0);
		end
	endtask

	////////////////////////////////////////////////////////////
	// monitor and timeout
	////////////////////////////////////////////////////////////

	// outputs are sampled on the falling edge, half a cycle after they settle
	always @(negedge clk_rxmac)
	begin
		if (arst)
		begin
			check_value("reset wrreq", 1'b0, rx8l_wrreq);
			check_value("reset sop", 1'b0, rx8l_sop);
			check_value("reset eop", 1'b0, rx8l_eop);
		end
		else if (rx8l_wrreq)
		begin
			if (exp_d.size() == 0)
				fail_run("an output beat came out with no packet left to match it");
			check_value({exp_name[0], " data"}, exp_d[0], rx8l_d);
			check_value({exp_name[0], " flags"}, exp_flags[0],
				{rx8l_sop, rx8l_eop, rx8l_fcs_valid, rx8l_fcs_error, rx8l_error});
			check_value({exp_name[0], " empty"}, exp_empty[0], rx8l_empty);
			exp_d.delete(0);
			exp_flags.delete(0);
			exp_empty.delete(0);
			exp_name.delete(0);
		end
		else
		begin
			check_value("idle sop", 1'b0, rx8l_sop);
			check_value("idle eop", 1'b0, rx8l_eop);
		end
	end

	always @(posedge clk_rxmac)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
			fail_run($sformatf("timeout after %0d cycles with %0d beats still missing",
				cycle_cnt, exp_d.size()));
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		clk_rxmac      = 1'b0;
		arst           = 1'b1;
		rx5l_d         = '0;
		rx5l_sop       = '0;
		rx5l_eop_bm    = '0;
		rx5l_valid     = 1'b0;
		rx5l_fcs_valid = 1'b0;
		rx5l_fcs_error = 1'b0;
		cyc_sop        = '0;
		cyc_bm         = '0;
		cyc_fv         = 1'b0;
		cyc_fe         = 1'b0;
		lane           = 4;
		seed           = 32'h1aa7_dfc8;
		cycle_cnt      = 0;
		cycle_limit    = 1000;
		read_patterns();
		repeat (8) @(negedge clk_rxmac);
		arst = 1'b0;
		for (int p = 0; p < n_pkts; p++)
			drive_packet(p);
		pad_cycle();
		send_idle();
		while (exp_d.size() != 0)
			@(negedge clk_rxmac);
		// extra cycles so a stray beat is still caught
		repeat (10) @(negedge clk_rxmac);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- rx_wide_patterns.txt
# length_bytes junk_words idle_cycles fcs_valid fcs_error
# junk words and valid-low cycles come before the packet on its line
64 0 1 1 0
200 2 1 1 0
1 0 0 1 1
8 3 0 1 0
9 0 0 0 0
60 1 0 1 0
65 0 2 1 0
128 0 1 1 1
17 2 0 1 0
33 0 0 1 0
40 1 0 0 0
300 0 1 1 0
7 4 0 1 0
16 0 0 1 1
72 0 1 1 0
24 1 0 1 0
120 0 1 1 0
3 0 0 1 0
47 2 0 1 0
192 0 1 1 1
56 0 0 1 0
12 0 0 1 0
68 3 2 1 0
100 0 1 0 0
5 1 0 1 0
36 0 0 1 0
129 0 1 1 0
20 0 0 1 1
256 1 2 1 0
44 0 0 1 0
31 0 0 1 0
80 0 1 1 0
2 6 0 1 0
64 0 0 1 0

//--- tb.f
rx_wide_pkg.sv
rx_lane_annotate.sv
rx_word_compact.sv
rx_sop_regroup.sv
rx_wide_528.sv
tb_rx_wide_528.sv

//--- Bender.yml
package:
  name: rx_wide_528

sources:
  # package first, then the blocks, then the top level
  - rx_wide_pkg.sv
  - rx_lane_annotate.sv
  - rx_word_compact.sv
  - rx_sop_regroup.sv
  - rx_wide_528.sv

  # testbench
  - target: test
    files:
      - tb_rx_wide_528.sv
